// ==== logic/sram_pkg.sv ====
package sram_pkg;

  // sram word address width
  localparam int addr_w = 8;

  // command and response word width
  localparam int data_w = 16;

  // data wires actually bonded to the chip, narrower than data_w
  localparam int pin_data_w = 12;

  // response fifo, depth is a power of two
  localparam int fifo_addr_w = 2;
  localparam int fifo_depth = 1 << fifo_addr_w;

  typedef logic [addr_w-1:0] sram_addr_t;
  typedef logic [data_w-1:0] sram_word_t;
  typedef logic [pin_data_w-1:0] pin_word_t;

  // single word command, reads ignore wr_data
  typedef struct packed {
    sram_addr_t addr;
    logic       wr_en;
    sram_word_t wr_data;
  } sram_cmd_t;

  // read response, kept as a struct so fields can be added later
  typedef struct packed {
    sram_word_t rd_data;
  } sram_rsp_t;

  // command sequencer states
  typedef enum logic [1:0] {
    state_idle,
    state_read,
    state_write
  } ctrl_state_t;

endpackage

// ==== logic/sync_fifo.sv ====
module sync_fifo (
  input  logic               clk,
  input  logic               rst_n,

  input  logic               w_inc,
  input  sram_pkg::pin_word_t w_data,
  output logic               w_half_full,

  input  logic               r_inc,
  output sram_pkg::pin_word_t r_data,
  output logic               r_empty
);

  // pointers carry one extra wrap bit so full and empty differ
  logic [sram_pkg::fifo_addr_w:0]   w_ptr;
  logic [sram_pkg::fifo_addr_w:0]   r_ptr;
  logic [sram_pkg::fifo_addr_w:0]   count;
  logic [sram_pkg::fifo_addr_w-1:0] w_addr;
  logic [sram_pkg::fifo_addr_w-1:0] r_addr;
  logic                             full;
  logic                             do_write;
  logic                             do_read;

  sram_pkg::pin_word_t mem [sram_pkg::fifo_depth];

  assign w_addr = w_ptr[sram_pkg::fifo_addr_w-1:0];
  assign r_addr = r_ptr[sram_pkg::fifo_addr_w-1:0];

  assign count = w_ptr - r_ptr;

  // full when the index matches and the wrap bit differs
  assign full = (w_addr == r_addr) &&
                (w_ptr[sram_pkg::fifo_addr_w] != r_ptr[sram_pkg::fifo_addr_w]);

  assign r_empty = (w_ptr == r_ptr);

  assign w_half_full = (count >= (sram_pkg::fifo_addr_w + 1)'(sram_pkg::fifo_depth / 2));

  // requests against a full or empty buffer are ignored
  assign do_write = w_inc && !full;
  assign do_read  = r_inc && !r_empty;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_ptr <= '0;
    end else if (do_write) begin
      w_ptr <= w_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_ptr <= '0;
    end else if (do_read) begin
      r_ptr <= r_ptr + 1'b1;
    end
  end

  // storage write port
  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[w_addr] <= w_data;
    end
  end

  // head entry is visible without a read strobe
  assign r_data = mem[r_addr];

endmodule

// ==== logic/sram_pad_io.sv ====
module sram_pad_io (
  input  logic                clk,
  input  logic                rst_n,

  // from the command sequencer
  input  sram_pkg::sram_addr_t pad_addr,
  input  logic                pad_wr_en,
  input  sram_pkg::pin_word_t  pad_wr_data,
  input  logic                pad_we_n,
  input  logic                pad_oe_n,
  output sram_pkg::pin_word_t  pad_rd_data,
  output logic                pad_rd_valid,

  // chip pins
  output sram_pkg::sram_addr_t sram_addr,
  inout  wire sram_pkg::pin_word_t sram_data,
  output logic                sram_we_n,
  output logic                sram_oe_n,
  output logic                sram_ce_n
);

  logic                wr_en_q;
  sram_pkg::pin_word_t wr_data_q;
  sram_pkg::pin_word_t rd_sample;

  // oe_n delayed by one and two cycles behind the pin
  logic [1:0] rd_oe_sr;

  // strobes and chip select
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sram_we_n <= 1'b1;
      sram_oe_n <= 1'b1;
      sram_ce_n <= 1'b1;
      wr_en_q   <= 1'b0;
    end else begin
      sram_we_n <= pad_we_n;
      sram_oe_n <= pad_oe_n;
      // chip stays selected once out of reset
      sram_ce_n <= 1'b0;
      wr_en_q   <= pad_wr_en;
    end
  end

  always_ff @(posedge clk) begin
    sram_addr <= pad_addr;
    wr_data_q <= pad_wr_data;
  end

  // bus is released unless a write is being driven
  assign sram_data = wr_en_q ? wr_data_q : 'z;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_oe_sr <= 2'b11;
    end else begin
      rd_oe_sr <= {rd_oe_sr[0], sram_oe_n};
    end
  end

  // sample the pins at the end of the cycle oe_n is low there
  always_ff @(posedge clk) begin
    if (!sram_oe_n) begin
      rd_sample <= sram_data;
    end
  end

  // hand the sample on one cycle later, aligned with the valid pulse
  always_ff @(posedge clk) begin
    if (!rd_oe_sr[0]) begin
      pad_rd_data <= rd_sample;
    end
  end

  assign pad_rd_valid = !rd_oe_sr[1];

endmodule

// ==== logic/sram_io_if.sv ====
module sram_io_if (
  input  logic                 clk,
  input  logic                 rst_n,

  // command port
  input  logic                 cmd_valid,
  output logic                 cmd_ready,
  input  sram_pkg::sram_cmd_t  cmd,

  // response port
  output logic                 rsp_valid,
  input  logic                 rsp_ready,
  output sram_pkg::sram_rsp_t  rsp,

  // chip pins
  output sram_pkg::sram_addr_t sram_addr,
  inout  wire sram_pkg::pin_word_t sram_data,
  output logic                 sram_we_n,
  output logic                 sram_oe_n,
  output logic                 sram_ce_n
);

  sram_pkg::ctrl_state_t state;
  sram_pkg::ctrl_state_t state_next;

  // pad link
  sram_pkg::sram_addr_t pad_addr;
  logic                 pad_wr_en;
  sram_pkg::pin_word_t  pad_wr_data;
  logic                 pad_we_n;
  logic                 pad_oe_n;
  sram_pkg::pin_word_t  pad_rd_data;
  logic                 pad_rd_valid;

  // response fifo
  logic                 fifo_w_half_full;
  logic                 fifo_r_empty;
  sram_pkg::pin_word_t  fifo_r_data;

  logic                 cmd_accept;

  sram_pad_io u_pad (
    .clk          (clk),
    .rst_n        (rst_n),
    .pad_addr     (pad_addr),
    .pad_wr_en    (pad_wr_en),
    .pad_wr_data  (pad_wr_data),
    .pad_we_n     (pad_we_n),
    .pad_oe_n     (pad_oe_n),
    .pad_rd_data  (pad_rd_data),
    .pad_rd_valid (pad_rd_valid),
    .sram_addr    (sram_addr),
    .sram_data    (sram_data),
    .sram_we_n    (sram_we_n),
    .sram_oe_n    (sram_oe_n),
    .sram_ce_n    (sram_ce_n)
  );

  // stall new commands once two reads are queued, which leaves room
  // for the reads still in the pad pipeline
  assign cmd_ready  = (state == sram_pkg::state_idle) && !fifo_w_half_full;
  assign cmd_accept = cmd_valid && cmd_ready;

  always_comb begin
    state_next = state;
    case (state)
      sram_pkg::state_idle: begin
        if (cmd_accept) begin
          if (cmd.wr_en) begin
            state_next = sram_pkg::state_write;
          end else begin
            state_next = sram_pkg::state_read;
          end
        end
      end
      sram_pkg::state_read: begin
        state_next = sram_pkg::state_idle;
      end
      sram_pkg::state_write: begin
        state_next = sram_pkg::state_idle;
      end
      default: begin
        state_next = sram_pkg::state_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= sram_pkg::state_idle;
    end else begin
      state <= state_next;
    end
  end

  // address and data are loaded on the accepting edge
  always_ff @(posedge clk) begin
    if (state_next != sram_pkg::state_idle) begin
      pad_addr <= cmd.addr;
    end
    if (state_next == sram_pkg::state_write) begin
      // upper command bits have no wires to the chip
      pad_wr_data <= cmd.wr_data[sram_pkg::pin_data_w-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pad_we_n  <= 1'b1;
      pad_oe_n  <= 1'b1;
      pad_wr_en <= 1'b0;
    end else begin
      pad_we_n  <= (state_next != sram_pkg::state_write);
      pad_oe_n  <= (state_next != sram_pkg::state_read);
      // keep driving one cycle beyond the we_n pulse for hold time
      pad_wr_en <= (state_next == sram_pkg::state_write) ||
                   (state == sram_pkg::state_write);
    end
  end

  sync_fifo u_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .w_inc       (pad_rd_valid),
    .w_data      (pad_rd_data),
    .w_half_full (fifo_w_half_full),
    .r_inc       (rsp_valid && rsp_ready),
    .r_data      (fifo_r_data),
    .r_empty     (fifo_r_empty)
  );

  assign rsp_valid   = !fifo_r_empty;
  // bits above the pin width read back as zero
  assign rsp.rd_data = {{(sram_pkg::data_w - sram_pkg::pin_data_w){1'b0}}, fifo_r_data};

endmodule

// ==== logic/sram_ctrl_top.sv ====
module sram_ctrl_top (
  input  logic                 clk,
  input  logic                 rst_n,

  // command port
  input  logic                 cmd_valid,
  output logic                 cmd_ready,
  input  sram_pkg::sram_cmd_t  cmd,

  // response port
  output logic                 rsp_valid,
  input  logic                 rsp_ready,
  output sram_pkg::sram_rsp_t  rsp,

  // chip pins
  output sram_pkg::sram_addr_t sram_addr,
  inout  wire sram_pkg::pin_word_t sram_data,
  output logic                 sram_we_n,
  output logic                 sram_oe_n,
  output logic                 sram_ce_n
);

  // one chip behind one sequencer
  // a striping layer would place several of these side by side
  sram_io_if u_io_if (
    .clk       (clk),
    .rst_n     (rst_n),

    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd       (cmd),

    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp),

    .sram_addr (sram_addr),
    .sram_data (sram_data),
    .sram_we_n (sram_we_n),
    .sram_oe_n (sram_oe_n),
    .sram_ce_n (sram_ce_n)
  );

endmodule

// ==== tb/sram_chip_model.sv ====
module sram_chip_model (
  input  sram_pkg::sram_addr_t addr,
  inout  wire sram_pkg::pin_word_t data,
  input  logic                 we_n,
  input  logic                 oe_n,
  input  logic                 ce_n
);

  localparam int depth = 1 << sram_pkg::addr_w;

  sram_pkg::pin_word_t mem [depth];

  // set when we_n falls with the chip selected
  logic write_armed;

  // known power-up content, every address bit affects the word
  initial begin
    int a;
    write_armed = 1'b0;
    for (a = 0; a < depth; a++) begin
      mem[a] = sram_pkg::pin_word_t'(a * 3) ^ 12'h5a5;
    end
  end

  always @(negedge we_n) begin
    write_armed = !ce_n;
  end

  // the write completes on the rising edge of we_n
  always @(posedge we_n) begin
    if (write_armed) begin
      mem[addr] = data;
    end
    write_armed = 1'b0;
  end

  // asynchronous read, bus released unless selected and output enabled
  assign data = (!ce_n && !oe_n && we_n) ? mem[addr] : 'z;

endmodule

// ==== tb/sram_io_if_properties.sv ====
module sram_io_if_properties (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  cmd_valid,
  input logic                  cmd_ready,
  input sram_pkg::sram_cmd_t   cmd,
  input logic                  rsp_valid,
  input logic                  rsp_ready,
  input sram_pkg::sram_rsp_t   rsp,
  input logic                  pad_we_n,
  input logic                  pad_oe_n,
  input logic                  sram_we_n,
  input logic                  sram_oe_n,
  input logic                  pad_rd_valid,
  input logic                  fifo_full,
  input sram_pkg::ctrl_state_t state
);

  // strobes are exclusive at the pad link and at the pins
  a_strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    (pad_we_n || pad_oe_n) && (sram_we_n || sram_oe_n))
    else $error("we_n and oe_n low in the same cycle");

  a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else $error("response changed or vanished while stalled");

  // write strobe only in the cycle after a write was accepted
  a_we_after_write: assert property (@(posedge clk) disable iff (!rst_n)
    !pad_we_n |-> $past(cmd_valid && cmd_ready && cmd.wr_en) &&
                  (state == sram_pkg::state_write))
    else $error("pad_we_n low without an accepted write");

  a_fifo_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    pad_rd_valid |-> !fifo_full)
    else $error("response fifo written while full");

endmodule

bind sram_io_if sram_io_if_properties u_props (
  .clk          (clk),
  .rst_n        (rst_n),
  .cmd_valid    (cmd_valid),
  .cmd_ready    (cmd_ready),
  .cmd          (cmd),
  .rsp_valid    (rsp_valid),
  .rsp_ready    (rsp_ready),
  .rsp          (rsp),
  .pad_we_n     (pad_we_n),
  .pad_oe_n     (pad_oe_n),
  .sram_we_n    (sram_we_n),
  .sram_oe_n    (sram_oe_n),
  .pad_rd_valid (pad_rd_valid),
  .fifo_full    (u_fifo.full),
  .state        (state)
);

// ==== tb/tb_sram_ctrl.sv ====
module tb_sram_ctrl;

  localparam int timeout_cycles = 200;

  logic                 clk;
  logic                 rst_n;
  logic                 cmd_valid;
  logic                 cmd_ready;
  sram_pkg::sram_cmd_t  cmd;
  logic                 rsp_valid;
  logic                 rsp_ready;
  sram_pkg::sram_rsp_t  rsp;
  sram_pkg::sram_addr_t sram_addr;
  wire sram_pkg::pin_word_t sram_data;
  logic                 sram_we_n;
  logic                 sram_oe_n;
  logic                 sram_ce_n;

  integer               seed;
  int                   mismatch_count;
  int                   failure_count;
  bit                   timed_out;
  int                   reads_accepted;
  int                   rsp_count;
  bit                   ready_random;
  int                   stall_cycles;
  sram_pkg::sram_word_t last_rsp;
  sram_pkg::sram_word_t exp_q [$];
  sram_pkg::pin_word_t  ref_mem [1 << sram_pkg::addr_w];

  sram_ctrl_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd       (cmd),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp),
    .sram_addr (sram_addr),
    .sram_data (sram_data),
    .sram_we_n (sram_we_n),
    .sram_oe_n (sram_oe_n),
    .sram_ce_n (sram_ce_n)
  );

  sram_chip_model sram_chip (
    .addr (sram_addr),
    .data (sram_data),
    .we_n (sram_we_n),
    .oe_n (sram_oe_n),
    .ce_n (sram_ce_n)
  );

  always #4 clk = ~clk;

  // power-up content of the chip is address times 3 xor 5a5
  function automatic sram_pkg::pin_word_t pattern_word(input int a);
    return sram_pkg::pin_word_t'(a * 3) ^ 12'h5a5;
  endfunction

  task automatic check_equal(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    assert (got === exp) else begin
      mismatch_count++;
      $display("ERROR: %s = 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    failure_count++;
    timed_out = 1'b1;
    $display("timeout: %s within %0d cycles", what, timeout_cycles);
  endtask

  // reference model follows accepted commands and checks responses in order
  always @(posedge clk) begin
    sram_pkg::sram_word_t expected;
    if (rst_n) begin
      if (cmd_valid && cmd_ready) begin
        if (cmd.wr_en) begin
          ref_mem[cmd.addr] = cmd.wr_data[sram_pkg::pin_data_w-1:0];
        end else begin
          exp_q.push_back(sram_pkg::sram_word_t'(ref_mem[cmd.addr]));
          reads_accepted++;
        end
      end
      if (rsp_valid && rsp_ready) begin
        rsp_count++;
        assert (exp_q.size() != 0) else begin
          failure_count++;
          $display("response returned with no read outstanding");
        end
        if (exp_q.size() != 0) begin
          expected = exp_q.pop_front();
          check_equal("rsp.rd_data", rsp.rd_data, expected);
          last_rsp = rsp.rd_data;
        end
      end
    end
  end

  // response back-pressure holds rsp_ready low for a stall or at random half the time
  always @(posedge clk) begin
    #1;
    if (stall_cycles > 0) begin
      rsp_ready = 1'b0;
      stall_cycles--;
    end else if (ready_random) begin
      rsp_ready = ($random(seed) & 1) != 0;
    end else begin
      rsp_ready = 1'b1;
    end
  end

  // called 1 unit after an edge, returns 1 unit after the accepting edge
  task automatic send_cmd(input sram_pkg::sram_cmd_t c);
    int  n;
    bit  done;
    n = 0;
    done = 1'b0;
    cmd = c;
    cmd_valid = 1'b1;
    while (!done && !timed_out) begin
      @(posedge clk);
      if (cmd_ready) begin
        done = 1'b1;
      end else begin
        n++;
        if (n >= timeout_cycles) begin
          report_timeout("command was not accepted");
        end
      end
    end
    #1;
    cmd_valid = 1'b0;
  endtask

  task automatic send_read(input sram_pkg::sram_addr_t a);
    sram_pkg::sram_cmd_t c;
    c = '0;
    c.addr = a;
    send_cmd(c);
  endtask

  task automatic send_write(input sram_pkg::sram_addr_t a, input sram_pkg::sram_word_t d);
    sram_pkg::sram_cmd_t c;
    c.addr = a;
    c.wr_en = 1'b1;
    c.wr_data = d;
    send_cmd(c);
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || rsp_valid) && !timed_out) begin
      @(posedge clk);
      #1;
      n++;
      if (n >= timeout_cycles) begin
        report_timeout("outstanding reads did not return");
      end
    end
  endtask

  // an isolated read into an empty fifo raises rsp_valid 4 cycles after acceptance
  task automatic check_read_latency(input sram_pkg::sram_addr_t a);
    int n;
    bit seen;
    n = 0;
    seen = 1'b0;
    send_read(a);
    while (!seen && !timed_out) begin
      @(posedge clk);
      #1;
      n++;
      if (rsp_valid) begin
        seen = 1'b1;
      end else if (n >= timeout_cycles) begin
        report_timeout("rsp_valid did not rise after a read");
      end
    end
    if (seen) begin
      check_equal("rsp_valid latency", 16'(n), 16'd4);
    end
  endtask

  task automatic run_random_mix(input int count);
    int                  i;
    logic [31:0]         r;
    sram_pkg::sram_cmd_t c;
    for (i = 0; i < count && !timed_out; i++) begin
      r = $random(seed);
      // an idle cycle now and then
      if (r[11:10] == 2'b11) begin
        @(posedge clk);
        #1;
      end
      // mostly a small window so reads hit earlier writes
      c.addr = r[8] ? r[7:0] : {4'h0, r[3:0]};
      c.wr_en = r[9];
      c.wr_data = r[31:16];
      send_cmd(c);
    end
  endtask

  initial begin
    int a;
    seed = 72912;
    clk = 1'b0;
    rst_n = 1'b0;
    cmd_valid = 1'b0;
    cmd = '0;
    rsp_ready = 1'b1;
    ready_random = 1'b0;
    stall_cycles = 0;
    for (a = 0; a < (1 << sram_pkg::addr_w); a++) begin
      ref_mem[a] = pattern_word(a);
    end

    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_equal("rsp_valid", 16'(rsp_valid), 16'h0);
    check_equal("sram_we_n", 16'(sram_we_n), 16'h1);
    check_equal("sram_oe_n", 16'(sram_oe_n), 16'h1);
    check_equal("cmd_ready", 16'(cmd_ready), 16'h1);

    // only the low 12 bits reach the chip
    send_write(8'h21, 16'hbeef);
    send_read(8'h21);
    wait_drained();
    check_equal("rsp.rd_data", last_rsp, 16'h0eef);

    // 0xc3 * 3 = 0x249 and 0x249 xor 0x5a5 = 0x7ec
    send_read(8'hc3);
    wait_drained();
    check_equal("rsp.rd_data", last_rsp, 16'h07ec);

    if (!timed_out) begin
      check_read_latency(8'h05);
    end
    wait_drained();

    ready_random = 1'b1;
    run_random_mix(400);
    wait_drained();

    // long stall with cmd_valid held high across the blocked commands
    ready_random = 1'b0;
    stall_cycles = 40;
    send_read(8'h10);
    send_read(8'h11);
    send_write(8'h12, 16'h1234);
    send_read(8'h12);
    send_read(8'h13);
    send_read(8'h21);
    wait_drained();

    assert (rsp_count == reads_accepted) else begin
      failure_count++;
      $display("response count %0d does not match accepted reads %0d",
               rsp_count, reads_accepted);
    end

    $display("errors: %0d value mismatches, %0d other failures",
             mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== sram_ctrl.f ====
logic/sram_pkg.sv
logic/sync_fifo.sv
logic/sram_pad_io.sv
logic/sram_io_if.sv
logic/sram_ctrl_top.sv
tb/sram_chip_model.sv
tb/sram_io_if_properties.sv
tb/tb_sram_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# build and run the sram controller testbench with verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sram_ctrl \
  -f sram_ctrl.f \
  --Mdir obj_dir -o tb_sram_ctrl > compile.log 2>&1 \
  || { echo "compile failed, see compile.log"; exit 1; }

./obj_dir/tb_sram_ctrl > sim.log 2>&1

grep -q "^TEST PASS$" sim.log \
  && echo "simulation passed, see sim.log" \
  || { echo "simulation failed, see sim.log"; tail -n 20 sim.log; exit 1; }

exit 0
